// ==== mips_alu.sv ====
`timescale 1ns/10ps

module mips_alu (
	input  mips_cpu_pkg::alu_op_t op,
	input  logic [31:0]           a,
	input  logic [31:0]           b,
	input  logic [4:0]            shamt,
	output logic [31:0]           y
);
	logic signed_lt;
	logic unsigned_lt;

	assign signed_lt   = $signed(a) < $signed(b);
	assign unsigned_lt = a < b;

	always_comb begin
		case (op)
			mips_cpu_pkg::alu_add:
				y = a + b; // Wraps, no overflow trap
			mips_cpu_pkg::alu_sub:
				y = a - b;
			mips_cpu_pkg::alu_and:
				y = a & b;
			mips_cpu_pkg::alu_or:
				y = a | b;
			mips_cpu_pkg::alu_xor:
				y = a ^ b;
			mips_cpu_pkg::alu_slt:
				y = {31'd0, signed_lt};
			mips_cpu_pkg::alu_sltu:
				y = {31'd0, unsigned_lt};
			mips_cpu_pkg::alu_sll:
				y = b << shamt; // Shifts act on the rt operand
			mips_cpu_pkg::alu_srl:
				y = b >> shamt;
			mips_cpu_pkg::alu_sra:
				y = $unsigned($signed(b) >>> shamt); // Sign fill
			mips_cpu_pkg::alu_lui:
				y = {b[15:0], 16'd0};
			default:
				y = '0;
		endcase
	end

endmodule

// ==== mips_controller.sv ====
`timescale 1ns/10ps

module mips_controller (
	input logic [31:0] instr,
	mips_ctrl_if.ctrl  ctrl
);
	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] rt;

	assign op    = instr[mips_isa_pkg::op_lsb +: 6];
	assign funct = instr[mips_isa_pkg::funct_lsb +: 6];
	assign rt    = instr[mips_isa_pkg::rt_lsb +: 5]; // REGIMM selector

	always_comb begin
		ctrl.reg_write    = 1'b0; // Unknown opcode falls through as a no-op
		ctrl.dest_sel     = mips_cpu_pkg::dest_rt;
		ctrl.alu_src_imm  = 1'b0;
		ctrl.imm_zero_ext = 1'b0;
		ctrl.shift_var    = 1'b0;
		ctrl.alu_op       = mips_cpu_pkg::alu_add;
		ctrl.mem_write    = 1'b0;
		ctrl.mem_read     = 1'b0;
		ctrl.link         = 1'b0;
		ctrl.branch_kind  = mips_cpu_pkg::br_none;
		ctrl.jump_kind    = mips_cpu_pkg::jmp_none;
		case (op)
			mips_isa_pkg::op_rtype: begin
				ctrl.reg_write = 1'b1; // Cleared again for JR and unknown funct
				ctrl.dest_sel  = mips_cpu_pkg::dest_rd;
				case (funct)
					mips_isa_pkg::fn_addu: ctrl.alu_op = mips_cpu_pkg::alu_add;
					mips_isa_pkg::fn_subu: ctrl.alu_op = mips_cpu_pkg::alu_sub;
					mips_isa_pkg::fn_and:  ctrl.alu_op = mips_cpu_pkg::alu_and;
					mips_isa_pkg::fn_or:   ctrl.alu_op = mips_cpu_pkg::alu_or;
					mips_isa_pkg::fn_xor:  ctrl.alu_op = mips_cpu_pkg::alu_xor;
					mips_isa_pkg::fn_slt:  ctrl.alu_op = mips_cpu_pkg::alu_slt;
					mips_isa_pkg::fn_sltu: ctrl.alu_op = mips_cpu_pkg::alu_sltu;
					mips_isa_pkg::fn_sll:  ctrl.alu_op = mips_cpu_pkg::alu_sll; // shamt field
					mips_isa_pkg::fn_srl:  ctrl.alu_op = mips_cpu_pkg::alu_srl;
					mips_isa_pkg::fn_sra:  ctrl.alu_op = mips_cpu_pkg::alu_sra;
					mips_isa_pkg::fn_sllv: begin
						ctrl.alu_op    = mips_cpu_pkg::alu_sll;
						ctrl.shift_var = 1'b1; // Amount from rs[4:0]
					end
					mips_isa_pkg::fn_srlv: begin
						ctrl.alu_op    = mips_cpu_pkg::alu_srl;
						ctrl.shift_var = 1'b1;
					end
					mips_isa_pkg::fn_srav: begin
						ctrl.alu_op    = mips_cpu_pkg::alu_sra;
						ctrl.shift_var = 1'b1;
					end
					mips_isa_pkg::fn_jr: begin
						ctrl.reg_write = 1'b0; // Jump only
						ctrl.jump_kind = mips_cpu_pkg::jmp_register;
					end
					mips_isa_pkg::fn_jalr: begin
						ctrl.link      = 1'b1; // PC+4 into rd
						ctrl.jump_kind = mips_cpu_pkg::jmp_register;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			mips_isa_pkg::op_regimm: begin
				case (rt)
					mips_isa_pkg::rt_bltz: ctrl.branch_kind = mips_cpu_pkg::br_ltz;
					mips_isa_pkg::rt_bgez: ctrl.branch_kind = mips_cpu_pkg::br_gez;
					mips_isa_pkg::rt_bltzal, mips_isa_pkg::rt_bgezal: begin
						ctrl.branch_kind = rt[0] ? mips_cpu_pkg::br_gez : mips_cpu_pkg::br_ltz;
						ctrl.reg_write   = 1'b1; // Links whether taken or not
						ctrl.dest_sel    = mips_cpu_pkg::dest_ra;
						ctrl.link        = 1'b1;
					end
					default: ctrl.branch_kind = mips_cpu_pkg::br_none;
				endcase
			end
			mips_isa_pkg::op_beq:  ctrl.branch_kind = mips_cpu_pkg::br_eq;
			mips_isa_pkg::op_bne:  ctrl.branch_kind = mips_cpu_pkg::br_ne;
			mips_isa_pkg::op_blez: ctrl.branch_kind = mips_cpu_pkg::br_lez;
			mips_isa_pkg::op_bgtz: ctrl.branch_kind = mips_cpu_pkg::br_gtz;
			mips_isa_pkg::op_j:    ctrl.jump_kind   = mips_cpu_pkg::jmp_target;
			mips_isa_pkg::op_jal: begin
				ctrl.jump_kind = mips_cpu_pkg::jmp_target;
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel  = mips_cpu_pkg::dest_ra; // Always r31
				ctrl.link      = 1'b1;
			end
			mips_isa_pkg::op_addiu, mips_isa_pkg::op_slti, mips_isa_pkg::op_sltiu,
			mips_isa_pkg::op_andi, mips_isa_pkg::op_ori, mips_isa_pkg::op_xori,
			mips_isa_pkg::op_lui: begin
				ctrl.reg_write    = 1'b1;
				ctrl.alu_src_imm  = 1'b1;
				ctrl.imm_zero_ext = op inside {mips_isa_pkg::op_andi, mips_isa_pkg::op_ori,
					mips_isa_pkg::op_xori}; // Logic ops take the raw 16 bits
				case (op)
					mips_isa_pkg::op_slti:  ctrl.alu_op = mips_cpu_pkg::alu_slt;
					mips_isa_pkg::op_sltiu: ctrl.alu_op = mips_cpu_pkg::alu_sltu;
					mips_isa_pkg::op_andi:  ctrl.alu_op = mips_cpu_pkg::alu_and;
					mips_isa_pkg::op_ori:   ctrl.alu_op = mips_cpu_pkg::alu_or;
					mips_isa_pkg::op_xori:  ctrl.alu_op = mips_cpu_pkg::alu_xor;
					mips_isa_pkg::op_lui:   ctrl.alu_op = mips_cpu_pkg::alu_lui;
					default:                ctrl.alu_op = mips_cpu_pkg::alu_add; // ADDIU
				endcase
			end
			mips_isa_pkg::op_lw: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1; // Base plus offset
				ctrl.mem_read    = 1'b1;
			end
			mips_isa_pkg::op_sw: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
			end
			default: ctrl.reg_write = 1'b0;
		endcase
	end

endmodule

// ==== mips_cpu_harvard.sv ====
`timescale 1ns/10ps

module mips_cpu_harvard (
	input  logic        clk,
	input  logic        reset,
	output logic        active,
	output logic [31:0] register_v0,

	input  logic        clk_enable,

	output logic [31:0] instr_address,  // Current PC
	input  logic [31:0] instr_readdata, // Fetched in the same cycle

	output logic [31:0] data_address,   // ALU result
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata, // rt value
	input  logic [31:0] data_readdata
);
	mips_ctrl_if ctrl_bus ();

	mips_controller u_controller (
		.instr (instr_readdata),
		.ctrl  (ctrl_bus)
	);

	mips_datapath u_datapath (
		.clk           (clk),
		.reset         (reset),
		.clk_enable    (clk_enable),
		.instr         (instr_readdata),
		.data_readdata (data_readdata),
		.ctrl          (ctrl_bus),
		.pc            (instr_address),
		.alu_result    (data_address),
		.store_data    (data_writedata),
		.active        (active),
		.v0            (register_v0),
		.mem_write_en  (data_write),
		.mem_read_en   (data_read)
	);

endmodule

// ==== mips_cpu_pkg.sv ====
package mips_cpu_pkg;

	// ALU operation select
	typedef enum logic [4:0] {
		alu_add,  // Wrapping add
		alu_sub,  // Wrapping subtract
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,  // Signed compare
		alu_sltu, // Unsigned compare
		alu_sll,
		alu_srl,
		alu_sra,
		alu_lui   // Immediate to upper half
	} alu_op_t;

	// Branch condition, evaluated in the datapath
	typedef enum logic [2:0] {
		br_none,
		br_eq,
		br_ne,
		br_lez,
		br_gtz,
		br_ltz,
		br_gez
	} branch_kind_t;

	// Jump source
	typedef enum logic [1:0] {
		jmp_none,
		jmp_target,   // J, JAL
		jmp_register  // JR, JALR
	} jump_kind_t;

	// Register file write address select
	typedef enum logic [1:0] {
		dest_rt,
		dest_rd,
		dest_ra
	} dest_sel_t;

	localparam logic [31:0] reset_vector = 32'hBFC0_0000; // First fetch address

endpackage

// ==== mips_cpu_sva.sv ====
`timescale 1ns/10ps

module mips_cpu_sva (
	input logic        clk,
	input logic        reset,
	input logic        active,
	input logic        clk_enable,
	input logic        data_write,
	input logic        data_read,
	input logic [31:0] instr_address
);
	no_write_when_halted: assert property (@(posedge clk) disable iff (reset)
		!active |-> !data_write)
		else $error("data_write high while the CPU is halted");

	// PC frozen across a disabled edge
	pc_holds_on_stall: assert property (@(posedge clk) disable iff (reset)
		!clk_enable |=> $stable(instr_address))
		else $error("instr_address moved across an edge without clk_enable");

	read_write_exclusive: assert property (@(posedge clk) !(data_write && data_read))
		else $error("data_write and data_read high together");

	pc_at_reset: assert property (@(posedge clk)
		reset |-> instr_address == mips_cpu_pkg::reset_vector)
		else $error("instr_address not at the reset vector during reset");

endmodule

// ==== mips_cpu_tb.sv ====
`timescale 1ns/10ps

module mips_cpu_tb;
	localparam int imem_words = 256;
	localparam int max_steps  = 2000; // Bound on reference and DUT run length

	logic        clk, reset, restart, clk_enable, active, data_write, data_read;
	logic [31:0] register_v0, instr_address, instr_readdata, data_address;
	logic [31:0] data_writedata, data_readdata, fetch_off, pc_at_edge;
	logic [31:0] imem [imem_words];
	logic [31:0] dmem [256];
	logic [31:0] ref_mem [256];
	logic [31:0] prog [$];
	logic        en_at_edge, stall_mode;
	int          retired, errors, passed, failed;

	tb_clock_gen clk_gen (.restart(restart), .clk(clk), .reset(reset));

	mips_cpu_harvard UUT (.*);

	bind mips_cpu_harvard mips_cpu_sva sva_checks (.*);

	// Instruction memory by word offset, SW r0 outside the program
	assign fetch_off      = (instr_address - mips_cpu_pkg::reset_vector) >> 2;
	assign instr_readdata = (fetch_off < imem_words) ? imem[fetch_off[7:0]]
		: {mips_isa_pkg::op_sw, 10'd0, 16'd0}; // Store after the halt must stay idle
	assign data_readdata  = data_read ? dmem[data_address[9:2]] : 32'hdead_beef; // 1 KB window

	always @(posedge clk) begin
		pc_at_edge = instr_address; // Old PC, before the edge updates it
		en_at_edge = clk_enable;
		if (data_write)
			dmem[data_address[9:2]] <= data_writedata;
		if (clk_enable && active && !reset)
			retired++; // One retire per enabled edge
	end

	always @(negedge clk) begin
		if (!en_at_edge && !reset)
			assert (instr_address == pc_at_edge) else begin
				$display("error %0t: instr_address expected %h got %h", $time, pc_at_edge,
					instr_address);
				errors++;
			end
	end

	always @(posedge clk) begin
		#1 clk_enable <= stall_mode ? ($urandom % 3 != 0) : 1'b1;
	end

	function automatic logic [31:0] enc_r(logic [5:0] fn, logic [4:0] rs, rt, rd, sa);
		return {6'd0, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [4:0] rnd_reg();
		return 5'(1 + $urandom % 8);
	endfunction

	function automatic void load_reg(logic [4:0] r, logic [31:0] v);
		prog.push_back(enc_i(mips_isa_pkg::op_lui, 5'd0, r, v[31:16]));
		prog.push_back(enc_i(mips_isa_pkg::op_ori, r, r, v[15:0]));
	endfunction

	function automatic void build_alu();
		logic [5:0] fns [13] = '{mips_isa_pkg::fn_addu, mips_isa_pkg::fn_subu,
			mips_isa_pkg::fn_and, mips_isa_pkg::fn_or, mips_isa_pkg::fn_xor, mips_isa_pkg::fn_slt,
			mips_isa_pkg::fn_sltu, mips_isa_pkg::fn_sll, mips_isa_pkg::fn_srl, mips_isa_pkg::fn_sra,
			mips_isa_pkg::fn_sllv, mips_isa_pkg::fn_srlv, mips_isa_pkg::fn_srav};
		logic [5:0] ops [7] = '{mips_isa_pkg::op_addiu, mips_isa_pkg::op_slti,
			mips_isa_pkg::op_sltiu, mips_isa_pkg::op_andi, mips_isa_pkg::op_ori,
			mips_isa_pkg::op_xori, mips_isa_pkg::op_lui};
		int k;
		prog.delete();
		for (int r = 1; r <= 8; r++)
			load_reg(5'(r), $urandom);
		repeat (40) begin
			k = $urandom % 20;
			if (k < 13)
				prog.push_back(enc_r(fns[k], rnd_reg(), rnd_reg(), rnd_reg(), 5'($urandom)));
			else
				prog.push_back(enc_i(ops[k-13], rnd_reg(), rnd_reg(), 16'($urandom)));
		end
		prog.push_back(enc_r(mips_isa_pkg::fn_jr, 5'd0, 5'd0, 5'd0, 5'd0)); // Halt
	endfunction

	function automatic void build_mem();
		prog.delete();
		for (int r = 1; r <= 8; r++)
			load_reg(5'(r), $urandom);
		repeat (30) begin
			if ($urandom % 2) // Base r0, so the offset is the address
				prog.push_back(enc_i(mips_isa_pkg::op_sw, 5'd0, rnd_reg(), 16'(4 * ($urandom % 64))));
			else
				prog.push_back(enc_i(mips_isa_pkg::op_lw, 5'd0, rnd_reg(), 16'(4 * ($urandom % 64))));
			prog.push_back(enc_r(mips_isa_pkg::fn_addu, rnd_reg(), 5'd2, 5'd2, 5'd0));
		end
		prog.push_back(enc_r(mips_isa_pkg::fn_jr, 5'd0, 5'd0, 5'd0, 5'd0));
	endfunction

	// Forward branches and jumps only, each skipping one instruction
	function automatic void build_flow();
		logic [5:0]  br_ops [4] = '{mips_isa_pkg::op_beq, mips_isa_pkg::op_bne,
			mips_isa_pkg::op_blez, mips_isa_pkg::op_bgtz};
		logic [4:0]  ri_codes [4] = '{mips_isa_pkg::rt_bltz, mips_isa_pkg::rt_bgez,
			mips_isa_pkg::rt_bltzal, mips_isa_pkg::rt_bgezal};
		logic [31:0] tgt;
		logic [4:0]  rs;
		int          k;
		prog.delete();
		for (int r = 1; r <= 8; r++)
			load_reg(5'(r), ($urandom % 4 == 0) ? 32'd0 : $urandom);
		repeat (24) begin
			k  = $urandom % 11;
			rs = rnd_reg();
			if (k < 2)
				prog.push_back(enc_i(br_ops[k], rs, ($urandom % 2) ? rs : rnd_reg(), 16'd1));
			else if (k < 4)
				prog.push_back(enc_i(br_ops[k], rs, 5'd0, 16'd1));
			else if (k < 8)
				prog.push_back(enc_i(mips_isa_pkg::op_regimm, rs, ri_codes[k-4], 16'd1));
			else if (k < 10) begin
				tgt = mips_cpu_pkg::reset_vector + 4 * (prog.size() + 2);
				prog.push_back({(k == 8) ? mips_isa_pkg::op_jal : mips_isa_pkg::op_j, tgt[27:2]});
			end else begin
				load_reg(5'd9, mips_cpu_pkg::reset_vector + 4 * (prog.size() + 4));
				prog.push_back(enc_r(mips_isa_pkg::fn_jalr, 5'd9, 5'd0, 5'd10, 5'd0));
			end
			prog.push_back(enc_i(mips_isa_pkg::op_addiu, 5'd2, 5'd2, 16'($urandom))); // Skippable
			prog.push_back(enc_r(mips_isa_pkg::fn_addu, 5'd31, 5'd2, 5'd2, 5'd0));
			prog.push_back(enc_r(mips_isa_pkg::fn_xor, 5'd10, 5'd2, 5'd2, 5'd0));
		end
		prog.push_back(enc_r(mips_isa_pkg::fn_jr, 5'd0, 5'd0, 5'd0, 5'd0));
	endfunction

	// Instruction-level model of the program on ref_mem
	function automatic void reference(output logic [31:0] exp_v0, output int exp_count);
		logic [31:0] r [32];
		logic [31:0] pc, ins, a, b, imm_s, imm_z, ea, next_pc, off;
		logic [5:0]  op, fn;
		logic [4:0]  rs, rt, rd, sa;
		bit          done;
		foreach (r[i])
			r[i] = '0;
		pc        = mips_cpu_pkg::reset_vector;
		exp_count = 0;
		done      = 0;
		while (!done && exp_count < max_steps) begin
			off = (pc - mips_cpu_pkg::reset_vector) >> 2;
			ins = (off < prog.size()) ? prog[off] : 32'd0;
			{op, rs, rt, rd, sa, fn} = ins;
			a       = r[rs];
			b       = r[rt];
			imm_s   = {{16{ins[15]}}, ins[15:0]};
			imm_z   = {16'd0, ins[15:0]};
			ea      = a + imm_s;
			next_pc = pc + 4;
			exp_count++;
			case (op)
				mips_isa_pkg::op_rtype:
					case (fn)
						mips_isa_pkg::fn_addu: r[rd] = a + b;
						mips_isa_pkg::fn_subu: r[rd] = a - b;
						mips_isa_pkg::fn_and:  r[rd] = a & b;
						mips_isa_pkg::fn_or:   r[rd] = a | b;
						mips_isa_pkg::fn_xor:  r[rd] = a ^ b;
						mips_isa_pkg::fn_slt:  r[rd] = ($signed(a) < $signed(b)) ? 1 : 0;
						mips_isa_pkg::fn_sltu: r[rd] = (a < b) ? 1 : 0;
						mips_isa_pkg::fn_sll:  r[rd] = b << sa;
						mips_isa_pkg::fn_srl:  r[rd] = b >> sa;
						mips_isa_pkg::fn_sra:  r[rd] = $signed(b) >>> sa;
						mips_isa_pkg::fn_sllv: r[rd] = b << a[4:0];
						mips_isa_pkg::fn_srlv: r[rd] = b >> a[4:0];
						mips_isa_pkg::fn_srav: r[rd] = $signed(b) >>> a[4:0];
						mips_isa_pkg::fn_jr:   next_pc = a;
						mips_isa_pkg::fn_jalr: begin
							r[rd]   = pc + 4;
							next_pc = a;
						end
						default: ;
					endcase
				mips_isa_pkg::op_regimm: begin
					if (rt[4])
						r[31] = pc + 4; // Linked even when not taken
					if (rt[0] ? !a[31] : a[31])
						next_pc = pc + 4 + (imm_s << 2);
				end
				mips_isa_pkg::op_beq:  if (a == b) next_pc = pc + 4 + (imm_s << 2);
				mips_isa_pkg::op_bne:  if (a != b) next_pc = pc + 4 + (imm_s << 2);
				mips_isa_pkg::op_blez: if ($signed(a) <= 0) next_pc = pc + 4 + (imm_s << 2);
				mips_isa_pkg::op_bgtz: if ($signed(a) > 0) next_pc = pc + 4 + (imm_s << 2);
				mips_isa_pkg::op_j, mips_isa_pkg::op_jal: begin
					if (op == mips_isa_pkg::op_jal)
						r[31] = pc + 4;
					next_pc = {next_pc[31:28], ins[25:0], 2'b00};
				end
				mips_isa_pkg::op_addiu: r[rt] = a + imm_s;
				mips_isa_pkg::op_slti:  r[rt] = ($signed(a) < $signed(imm_s)) ? 1 : 0;
				mips_isa_pkg::op_sltiu: r[rt] = (a < imm_s) ? 1 : 0;
				mips_isa_pkg::op_andi:  r[rt] = a & imm_z;
				mips_isa_pkg::op_ori:   r[rt] = a | imm_z;
				mips_isa_pkg::op_xori:  r[rt] = a ^ imm_z;
				mips_isa_pkg::op_lui:   r[rt] = {ins[15:0], 16'd0};
				mips_isa_pkg::op_lw:    r[rt] = ref_mem[ea[9:2]];
				mips_isa_pkg::op_sw:    ref_mem[ea[9:2]] = b;
				default: ;
			endcase
			r[0] = '0;
			// A jump to address zero stops the CPU
			if (next_pc == 0 && (op == mips_isa_pkg::op_j || op == mips_isa_pkg::op_jal
				|| (op == mips_isa_pkg::op_rtype && fn inside {mips_isa_pkg::fn_jr,
				mips_isa_pkg::fn_jalr})))
				done = 1;
			pc = next_pc;
		end
		exp_v0 = r[2];
	endfunction

	task automatic run_test(input string name, input bit stalls, input bit halt_check);
		logic [31:0] exp_v0;
		int          exp_count, cycles, start_errors;
		start_errors = errors;
		foreach (imem[i])
			imem[i] = (i < prog.size()) ? prog[i] : 32'd0;
		foreach (dmem[i]) begin
			dmem[i]    = 32'hc0de_0000 ^ (i * 32'h0001_0104); // Pattern from the byte address
			ref_mem[i] = dmem[i];
		end
		reference(exp_v0, exp_count);
		stall_mode = stalls;
		@(posedge clk);
		#1 restart = 1'b1;
		retired = 0;
		@(posedge clk);
		#1 restart = 1'b0;
		cycles = 0;
		while (reset && cycles < 20) begin
			@(posedge clk);
			#2 cycles++;
		end
		retired = 0;
		assert (!reset) else begin
			$display("%s: reset never released", name);
			errors++;
		end
		assert (instr_address == mips_cpu_pkg::reset_vector) else begin
			$display("error %0t: instr_address expected %h got %h", $time,
				mips_cpu_pkg::reset_vector, instr_address);
			errors++;
		end
		assert (active) else begin
			$display("error %0t: active expected 1 got %b", $time, active);
			errors++;
		end
		cycles = 0;
		while (active && cycles < 4 * max_steps) begin
			@(posedge clk);
			#2 cycles++;
		end
		assert (!active) else begin
			$display("%s: timed out waiting for the CPU to halt", name);
			errors++;
		end
		assert (register_v0 == exp_v0) else begin
			$display("error %0t: register_v0 expected %h got %h", $time, exp_v0, register_v0);
			errors++;
		end
		assert (retired == exp_count) else begin
			$display("error %0t: retired expected %0d got %0d", $time, exp_count, retired);
			errors++;
		end
		foreach (dmem[i])
			assert (dmem[i] == ref_mem[i]) else begin
				$display("error %0t: dmem[%0d] expected %h got %h", $time, i, ref_mem[i], dmem[i]);
				errors++;
			end
		if (halt_check)
			repeat (20) begin
				@(posedge clk);
				#2;
				assert (!active && !data_write) else begin
					$display("error %0t: active/data_write expected 0/0 got %b/%b", $time,
						active, data_write);
					errors++;
				end
			end
		if (errors == start_errors) begin
			$display("%s: ok", name);
			passed++;
		end else begin
			$display("%s: mismatch", name);
			failed++;
		end
	endtask

	initial begin
		void'($urandom(32'hcfbf_168f));
		restart    = 1'b0;
		clk_enable = 1'b1;
		stall_mode = 1'b0;
		en_at_edge = 1'b1;
		errors     = 0;
		passed     = 0;
		failed     = 0;
		retired    = 0;
		build_alu();
		run_test("arith_logic", 1'b0, 1'b0);
		build_mem();
		run_test("load_store", 1'b0, 1'b0);
		build_flow();
		run_test("control_flow", 1'b0, 1'b0);
		run_test("stalls", 1'b1, 1'b0); // Same program, random clk_enable
		run_test("reset_halt", 1'b0, 1'b1);
		$display("passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (failed == 0 && errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== mips_ctrl_if.sv ====
`timescale 1ns/10ps

interface mips_ctrl_if;
	logic                       reg_write;    // Register file write
	mips_cpu_pkg::dest_sel_t    dest_sel;     // Which register is written
	logic                       alu_src_imm;  // Operand b from immediate
	logic                       imm_zero_ext; // Logic immediates
	logic                       shift_var;    // Shift amount from rs
	mips_cpu_pkg::alu_op_t      alu_op;
	logic                       mem_write;
	logic                       mem_read;     // Also selects load data for write back
	logic                       link;         // Write PC+4
	mips_cpu_pkg::branch_kind_t branch_kind;
	mips_cpu_pkg::jump_kind_t   jump_kind;

	modport ctrl (output reg_write, dest_sel, alu_src_imm, imm_zero_ext, shift_var,
		alu_op, mem_write, mem_read, link, branch_kind, jump_kind);

	modport dp (input reg_write, dest_sel, alu_src_imm, imm_zero_ext, shift_var,
		alu_op, mem_write, mem_read, link, branch_kind, jump_kind);

endinterface

// ==== mips_datapath.sv ====
`timescale 1ns/10ps

module mips_datapath (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	input  logic [31:0] instr,
	input  logic [31:0] data_readdata,
	mips_ctrl_if.dp     ctrl,
	output logic [31:0] pc,
	output logic [31:0] alu_result,
	output logic [31:0] store_data,
	output logic        active,
	output logic [31:0] v0,
	output logic        mem_write_en,
	output logic        mem_read_en
);
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [4:0]  shamt;
	logic [4:0]  wr_addr;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] imm_ext;
	logic [31:0] alu_b;
	logic [31:0] pc_plus4;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] pc_next;
	logic [31:0] wb_data;
	logic        branch_taken;
	logic        halt;

	assign rs = instr[mips_isa_pkg::rs_lsb +: 5];
	assign rt = instr[mips_isa_pkg::rt_lsb +: 5];
	assign rd = instr[mips_isa_pkg::rd_lsb +: 5];

	// Immediate and operands
	assign imm_ext = ctrl.imm_zero_ext ? {16'd0, instr[mips_isa_pkg::imm_w-1:0]}
		: {{16{instr[mips_isa_pkg::imm_w-1]}}, instr[mips_isa_pkg::imm_w-1:0]};
	assign alu_b = ctrl.alu_src_imm ? imm_ext : rt_val;
	assign shamt = ctrl.shift_var ? rs_val[4:0] : instr[mips_isa_pkg::sa_lsb +: 5];

	// Branch condition on register values only
	always_comb begin
		case (ctrl.branch_kind)
			mips_cpu_pkg::br_eq:  branch_taken = (rs_val == rt_val);
			mips_cpu_pkg::br_ne:  branch_taken = (rs_val != rt_val);
			mips_cpu_pkg::br_lez: branch_taken = rs_val[31] || (rs_val == '0);
			mips_cpu_pkg::br_gtz: branch_taken = !rs_val[31] && (rs_val != '0);
			mips_cpu_pkg::br_ltz: branch_taken = rs_val[31];
			mips_cpu_pkg::br_gez: branch_taken = !rs_val[31];
			default:              branch_taken = 1'b0;
		endcase
	end

	// Next PC, no delay slot
	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00}; // Offset in words
	assign jump_target   = {pc_plus4[31:28], instr[mips_isa_pkg::target_w-1:0], 2'b00};

	always_comb begin
		if (!active)
			pc_next = pc; // Halted, PC parked at zero
		else if (ctrl.jump_kind == mips_cpu_pkg::jmp_register)
			pc_next = rs_val;
		else if (ctrl.jump_kind == mips_cpu_pkg::jmp_target)
			pc_next = jump_target;
		else if (branch_taken)
			pc_next = branch_target;
		else
			pc_next = pc_plus4;
	end

	assign halt = active && (ctrl.jump_kind != mips_cpu_pkg::jmp_none) && (pc_next == '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc     <= mips_cpu_pkg::reset_vector;
			active <= 1'b1;
		end else if (clk_enable) begin
			pc <= pc_next;
			if (halt)
				active <= 1'b0; // Sticky until reset
		end
	end

	// Write back
	always_comb begin
		case (ctrl.dest_sel)
			mips_cpu_pkg::dest_rd: wr_addr = rd;
			mips_cpu_pkg::dest_ra: wr_addr = mips_isa_pkg::reg_ra;
			default:               wr_addr = rt;
		endcase
	end

	assign wb_data = ctrl.link ? pc_plus4 : (ctrl.mem_read ? data_readdata : alu_result);

	mips_regfile u_regfile (
		.clk         (clk),
		.reset       (reset),
		.write_en    (ctrl.reg_write && active && clk_enable), // One retire per enabled edge
		.read_addr_a (rs),
		.read_addr_b (rt),
		.write_addr  (wr_addr),
		.write_data  (wb_data),
		.read_data_a (rs_val),
		.read_data_b (rt_val),
		.v0          (v0)
	);

	mips_alu u_alu (
		.op    (ctrl.alu_op),
		.a     (rs_val),
		.b     (alu_b),
		.shamt (shamt),
		.y     (alu_result)
	);

	assign store_data   = rt_val;
	assign mem_write_en = ctrl.mem_write && active && clk_enable; // Memory writes on this edge
	assign mem_read_en  = ctrl.mem_read && active;

endmodule

// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

	// Instruction field positions
	localparam int op_lsb    = 26; // Opcode [31:26]
	localparam int rs_lsb    = 21; // Source register [25:21]
	localparam int rt_lsb    = 16; // Target register [20:16]
	localparam int rd_lsb    = 11; // Destination register [15:11]
	localparam int sa_lsb    = 6;  // Shift amount [10:6]
	localparam int funct_lsb = 0;  // Funct [5:0]
	localparam int imm_w     = 16; // Immediate width
	localparam int target_w  = 26; // Jump target width

	// Primary opcodes
	localparam logic [5:0] op_rtype  = 6'b000000; // SPECIAL, decode funct
	localparam logic [5:0] op_regimm = 6'b000001; // REGIMM, decode rt
	localparam logic [5:0] op_j      = 6'b000010;
	localparam logic [5:0] op_jal    = 6'b000011;
	localparam logic [5:0] op_beq    = 6'b000100;
	localparam logic [5:0] op_bne    = 6'b000101;
	localparam logic [5:0] op_blez   = 6'b000110;
	localparam logic [5:0] op_bgtz   = 6'b000111;
	localparam logic [5:0] op_addiu  = 6'b001001;
	localparam logic [5:0] op_slti   = 6'b001010;
	localparam logic [5:0] op_sltiu  = 6'b001011;
	localparam logic [5:0] op_andi   = 6'b001100;
	localparam logic [5:0] op_ori    = 6'b001101;
	localparam logic [5:0] op_xori   = 6'b001110;
	localparam logic [5:0] op_lui    = 6'b001111;
	localparam logic [5:0] op_lw     = 6'b100011;
	localparam logic [5:0] op_sw     = 6'b101011;

	// Funct codes under op_rtype
	localparam logic [5:0] fn_sll  = 6'b000000;
	localparam logic [5:0] fn_srl  = 6'b000010;
	localparam logic [5:0] fn_sra  = 6'b000011;
	localparam logic [5:0] fn_sllv = 6'b000100;
	localparam logic [5:0] fn_srlv = 6'b000110;
	localparam logic [5:0] fn_srav = 6'b000111;
	localparam logic [5:0] fn_jr   = 6'b001000;
	localparam logic [5:0] fn_jalr = 6'b001001;
	localparam logic [5:0] fn_addu = 6'b100001;
	localparam logic [5:0] fn_subu = 6'b100011;
	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_xor  = 6'b100110;
	localparam logic [5:0] fn_slt  = 6'b101010;
	localparam logic [5:0] fn_sltu = 6'b101011;

	// REGIMM branch selectors in the rt field
	localparam logic [4:0] rt_bltz   = 5'b00000;
	localparam logic [4:0] rt_bgez   = 5'b00001;
	localparam logic [4:0] rt_bltzal = 5'b10000;
	localparam logic [4:0] rt_bgezal = 5'b10001;

	// Architectural registers
	localparam logic [4:0] reg_v0 = 5'd2;  // Return value, exported to top
	localparam logic [4:0] reg_ra = 5'd31; // Link register

endpackage

// ==== mips_regfile.sv ====
`timescale 1ns/10ps

module mips_regfile (
	input  logic        clk,
	input  logic        reset,
	input  logic        write_en,
	input  logic [4:0]  read_addr_a,
	input  logic [4:0]  read_addr_b,
	input  logic [4:0]  write_addr,
	input  logic [31:0] write_data,
	output logic [31:0] read_data_a,
	output logic [31:0] read_data_b,
	output logic [31:0] v0
);
	logic [31:0] regs [32];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0; // Whole file starts clean
			end
		end else if (write_en && write_addr != 5'd0) begin
			regs[write_addr] <= write_data; // r0 never written
		end
	end

	// Reads see the old value in the write cycle
	assign read_data_a = (read_addr_a == 5'd0) ? '0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == 5'd0) ? '0 : regs[read_addr_b];
	assign v0          = regs[mips_isa_pkg::reg_v0]; // Debug export

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the MIPS testbench with Verilator

verilator --binary --timing -Wno-fatal -f src.f --top-module mips_cpu_tb -o sim \
	> build.log 2>&1 && ./obj_dir/sim > sim.log 2>&1 || {
	echo "build or simulation error, see build.log and sim.log"
	exit 1
}

cat sim.log
grep -q "tests failed" sim.log && exit 1
exit 0

// ==== src.f ====
mips_isa_pkg.sv
mips_cpu_pkg.sv
mips_ctrl_if.sv
mips_alu.sv
mips_regfile.sv
mips_controller.sv
mips_datapath.sv
mips_cpu_harvard.sv
mips_cpu_sva.sv
tb_clock_gen.sv
mips_cpu_tb.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	input  logic restart, // Rising edge starts a fresh reset
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
		forever begin
			@(posedge restart);
			reset = 1'b1;
			repeat (8) @(posedge clk); // Eight cycles each time
			#1 reset = 1'b0;
		end
	end

endmodule
